//--- Bender.yml
package:
  name: audio_codec

sources:
  # Design, package first
  - files:
      - verilog/audio_pkg.sv
      - verilog/audio_clk_gen.sv
      - verilog/tone_gen.sv
      - verilog/audio_dac_serializer.sv
      - verilog/audio_adc_deserializer.sv
      - verilog/audio_codec_top.sv

  # Testbench and bound checker
  - target: test
    files:
      - verification/audio_codec_chk.sv
      - verification/audio_codec_tb.sv

//--- flist.f
verilog/audio_pkg.sv
verilog/audio_clk_gen.sv
verilog/tone_gen.sv
verilog/audio_dac_serializer.sv
verilog/audio_adc_deserializer.sv
verilog/audio_codec_top.sv
verification/audio_codec_chk.sv
verification/audio_codec_tb.sv

//--- verification/audio_codec_chk.sv
`timescale 1ns/1ps

module audio_codec_chk (
    input logic               iCLK_18_4,
    input logic               iRST_N,
    input logic               aud_bck,
    input logic               aud_lrck,
    input logic               aud_adclrck,
    input audio_pkg::sample_t linein
);

    // Failure counts per property, summed into fail_count
    int adclrck_errs = 0;
    int lrck_errs    = 0;
    int linein_errs  = 0;
    int fail_count;

    assign fail_count = adclrck_errs + lrck_errs + linein_errs;

    // ADC side runs on the DAC word clock
    adclrck_same: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
        aud_adclrck == aud_lrck)
    else
    begin
        adclrck_errs = adclrck_errs + 1;
        $error("aud_adclrck differs from aud_lrck");
    end

    // Slot boundaries sit on bit clock falling edges
    lrck_on_bck_fall: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
        $changed(aud_lrck) |-> $fell(aud_bck))
    else
    begin
        lrck_errs = lrck_errs + 1;
        $error("aud_lrck changed away from a bit clock falling edge");
    end

    // Published word moves only with the left slot start
    linein_on_frame: assert property (@(posedge iCLK_18_4) disable iff (!iRST_N)
        $changed(linein) |-> $fell(aud_lrck))
    else
    begin
        linein_errs = linein_errs + 1;
        $error("linein changed outside a frame start");
    end

endmodule

bind audio_codec_top audio_codec_chk u_audio_codec_chk (
    .iCLK_18_4   (iCLK_18_4),
    .iRST_N      (iRST_N),
    .aud_bck     (aud_bck),
    .aud_lrck    (aud_lrck),
    .aud_adclrck (aud_adclrck),
    .linein      (linein)
);

//--- verification/audio_codec_tb.sv
`timescale 1ns/1ps

module audio_codec_tb;

    localparam int  CLK_PERIOD     = 100;
    // About 300 frames of 384 cycles, the tests take about 230
    localparam int  TIMEOUT_CYCLES = 120000;
    localparam int  RAND_SEED      = 32'h1629_a8e2;
    localparam real PI             = 3.141592653589793;

    // What the codec model sends on aud_adcdat
    typedef enum { ADC_IDLE, ADC_QUEUE, ADC_LOOP } adc_mode_t;

    logic               iCLK_18_4;
    logic               iRST_N;
    logic               tone_sel;
    audio_pkg::sample_t pulses;
    logic               aud_adcdat;
    logic               aud_bck;
    logic               aud_lrck;
    logic               aud_adclrck;
    logic               aud_data;
    audio_pkg::sample_t linein;

    // Codec model state
    adc_mode_t           adc_mode = ADC_IDLE;
    audio_pkg::sample_t  adc_q [$];
    audio_pkg::sample_t  adc_word = '0;
    audio_pkg::bit_idx_t adc_pos = 4'd15;
    logic                lrck_seen = 1'b0;
    int                  cycle_cnt = 0;
    time                 t_rel;

    audio_codec_top u_audio_codec_top (
        .iCLK_18_4   (iCLK_18_4),
        .iRST_N      (iRST_N),
        .tone_sel    (tone_sel),
        .pulses      (pulses),
        .aud_adcdat  (aud_adcdat),
        .aud_bck     (aud_bck),
        .aud_lrck    (aud_lrck),
        .aud_adclrck (aud_adclrck),
        .aud_data    (aud_data),
        .linein      (linein)
    );

    initial
    begin
        iCLK_18_4 = 1'b0;
        forever #(CLK_PERIOD / 2) iCLK_18_4 = ~iCLK_18_4;
    end

    //////////////////////////////////////////////////////////////////////////
    // Common tasks
    //////////////////////////////////////////////////////////////////////////
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: actual 0x%h, expected 0x%h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Run limit
    always @(posedge iCLK_18_4)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
            report_failure($sformatf("Timeout: run still going after %0d cycles",
                                     TIMEOUT_CYCLES));
    end

    // Left slot start, 1 ns past the edge where aud_lrck falls
    task automatic wait_frame();
        @(negedge aud_lrck);
        #1;
    endtask

    // Codec DAC side, both slots of one frame, MSB first
    task automatic collect_frame(output audio_pkg::sample_t left,
                                 output audio_pkg::sample_t right);
        logic [31:0] bits;
        bits = '0;
        repeat (2 * audio_pkg::SAMPLE_BITS)
        begin
            @(posedge aud_bck);
            bits = {bits[30:0], aud_data};
        end
        left  = bits[31:16];
        right = bits[15:0];
        wait_frame();
    endtask

    // Codec ADC side, new bit just after each bit clock falling edge
    always @(negedge aud_bck)
    begin
        #1;
        if (!aud_lrck && lrck_seen)
        begin
            adc_pos = 4'd15;
            if (adc_mode == ADC_QUEUE && adc_q.size() > 0)
                adc_word = adc_q.pop_front();
        end
        else
            adc_pos = adc_pos - 1'b1;
        lrck_seen = aud_lrck;
        case (adc_mode)
            ADC_QUEUE: aud_adcdat = adc_word[adc_pos];
            // Echo of the bit the DUT drives in this period
            ADC_LOOP:  aud_adcdat = aud_data;
            default:   aud_adcdat = 1'b0;
        endcase
    end

    // Sine point k, quarter wave mirrored into a symmetric period
    function automatic audio_pkg::sample_t sine_point(input int k);
        int  q;
        int  mag;
        real r;
        q = k % 24;
        if (q > 12)
            q = 24 - q;
        r   = 32767.0 * $sin(2.0 * PI * q / 48.0);
        mag = $rtoi(r + 0.5);
        if ((k % 48) >= 24)
            return audio_pkg::sample_t'(-mag);
        return audio_pkg::sample_t'(mag);
    endfunction

    //////////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////////
    task automatic test_reset_clocks();
        time t0;
        time t1;
        time t2;
        check_value("aud_bck", 32'(aud_bck), 32'd0);
        check_value("aud_lrck", 32'(aud_lrck), 32'd0);
        check_value("aud_data", 32'(aud_data), 32'd0);
        check_value("linein", 32'(linein), 32'd0);
        // First rise 6 cycles after reset, then a 12 cycle period
        @(posedge aud_bck);
        t0 = $time;
        @(posedge aud_bck);
        t1 = $time;
        check_value("aud_bck first rise", 32'((t0 - t_rel + 1) / CLK_PERIOD), 32'd6);
        check_value("aud_bck period", 32'((t1 - t0) / CLK_PERIOD), 32'd12);
        @(posedge aud_lrck);
        t0 = $time;
        #1;
        // Right slot, word clock high
        check_value("aud_adclrck", 32'(aud_adclrck), 32'd1);
        @(negedge aud_lrck);
        t1 = $time;
        #1;
        check_value("aud_adclrck", 32'(aud_adclrck), 32'd0);
        check_value("aud_lrck first fall", 32'((t1 - t_rel + 1) / CLK_PERIOD), 32'd384);
        @(posedge aud_lrck);
        t2 = $time;
        check_value("aud_lrck high time", 32'((t1 - t0) / CLK_PERIOD), 32'd192);
        check_value("aud_lrck period", 32'((t2 - t0) / CLK_PERIOD), 32'd384);
        wait_frame();
    endtask

    task automatic test_pulses_tx(input int frames);
        audio_pkg::sample_t held;
        audio_pkg::sample_t left;
        audio_pkg::sample_t right;
        tone_sel = 1'b0;
        pulses   = audio_pkg::sample_t'($urandom);
        wait_frame();
        repeat (frames)
        begin
            // Value taken at the frame start just passed
            held   = pulses;
            pulses = audio_pkg::sample_t'($urandom);
            collect_frame(left, right);
            check_value("aud_data left", 32'(left), 32'(held));
            check_value("aud_data right", 32'(right), 32'(held));
        end
    endtask

    task automatic test_adc_rx(input int frames);
        audio_pkg::sample_t sent;
        audio_pkg::sample_t word;
        sent = '0;
        for (int i = 0; i <= frames; i++)
        begin
            // Queued mid frame, the model picks it up at the next frame start
            @(posedge aud_lrck);
            adc_mode = ADC_QUEUE;
            word     = audio_pkg::sample_t'($urandom);
            adc_q.push_back(word);
            wait_frame();
            if (i > 0)
                check_value("linein", 32'(linein), 32'(sent));
            sent = word;
        end
    endtask

    task automatic test_loopback(input int frames);
        audio_pkg::sample_t sent;
        @(posedge aud_lrck);
        adc_mode = ADC_LOOP;
        wait_frame();
        tone_sel = 1'b0;
        sent     = pulses;
        pulses   = audio_pkg::sample_t'($urandom);
        repeat (frames)
        begin
            wait_frame();
            check_value("linein", 32'(linein), 32'(sent));
            sent   = pulses;
            pulses = audio_pkg::sample_t'($urandom);
        end
    endtask

    task automatic test_tone(input int frames);
        audio_pkg::sample_t words [$];
        audio_pkg::sample_t rights [$];
        audio_pkg::sample_t left;
        audio_pkg::sample_t right;
        int                 start;
        tone_sel = 1'b1;
        wait_frame();
        repeat (frames)
        begin
            collect_frame(left, right);
            words.push_back(left);
            rights.push_back(right);
        end
        // Two consecutive points pin down the table position
        start = -1;
        for (int k = 0; k < audio_pkg::TONE_POINTS; k++)
        begin
            if (start < 0 && words[0] == sine_point(k) && words[1] == sine_point(k + 1))
                start = k;
        end
        if (start < 0)
            report_failure("Tone: first frame words are not in the sine table");
        for (int i = 0; i < frames; i++)
        begin
            check_value("aud_data tone left", 32'(words[i]), 32'(sine_point(start + i)));
            check_value("aud_data tone right", 32'(rights[i]), 32'(sine_point(start + i)));
        end
    endtask

    initial
    begin
        iRST_N     = 1'b0;
        tone_sel   = 1'b0;
        pulses     = '0;
        aud_adcdat = 1'b0;
        void'($urandom(RAND_SEED));
        repeat (2) @(posedge iCLK_18_4);
        #1;
        iRST_N = 1'b1;
        t_rel  = $time;
        test_reset_clocks();
        test_pulses_tx(40);
        test_adc_rx(40);
        test_loopback(40);
        test_tone(100);
        if (u_audio_codec_top.u_audio_codec_chk.fail_count == 0)
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("Bound assertions failed %0d times",
                     u_audio_codec_top.u_audio_codec_chk.fail_count);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

//--- verilog/audio_adc_deserializer.sv
`timescale 1ns/1ps

module audio_adc_deserializer (
    input  logic               iCLK_18_4,
    input  logic               iRST_N,
    input  logic               bck_rise,
    input  logic               frame_start,
    input  logic               aud_adcdat,
    output audio_pkg::sample_t linein
);

    localparam audio_pkg::bit_idx_t MSB_IDX = audio_pkg::bit_idx_t'(audio_pkg::SAMPLE_BITS - 1);

    audio_pkg::sample_t  cap_word;
    audio_pkg::bit_idx_t cap_idx;

    ////////////////////////////////////////////////////////////////////////////
    // Capture pointer, MSB first
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge iCLK_18_4 or negedge iRST_N)
    begin
        if (!iRST_N)
            cap_idx <= MSB_IDX;
        else if (frame_start)
            cap_idx <= MSB_IDX;
        else if (bck_rise)
            cap_idx <= cap_idx - 1'b1;
    end

    // Right slot overwrites left slot after the wrap
    always_ff @(posedge iCLK_18_4)
    begin
        if (bck_rise)
            cap_word[cap_idx] <= aud_adcdat;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Published word
    ////////////////////////////////////////////////////////////////////////////
    // Holds the right slot of the previous frame
    always_ff @(posedge iCLK_18_4 or negedge iRST_N)
    begin
        if (!iRST_N)
            linein <= '0;
        else if (frame_start)
            linein <= cap_word;
    end

endmodule

//--- verilog/audio_clk_gen.sv
`timescale 1ns/1ps

module audio_clk_gen #(
    parameter int REF_CLK     = audio_pkg::DEF_REF_CLK,
    parameter int SAMPLE_RATE = audio_pkg::DEF_SAMPLE_RATE
) (
    input  logic iCLK_18_4,
    input  logic iRST_N,
    output logic aud_bck,
    output logic aud_lrck,
    output logic bck_rise,
    output logic bck_fall,
    output logic frame_start
);

    // Half periods in reference cycles
    // 2 slots of SAMPLE_BITS bits per frame, 2 half periods per bit
    localparam int BCK_HALF  = REF_CLK / (SAMPLE_RATE * audio_pkg::SAMPLE_BITS * 2 * 2);
    localparam int LRCK_HALF = REF_CLK / (SAMPLE_RATE * 2);
    localparam int BCK_W     = $clog2(BCK_HALF + 1);
    localparam int LRCK_W    = $clog2(LRCK_HALF + 1);

    logic [BCK_W-1:0]  bck_div;
    logic [LRCK_W-1:0] lrck_div;
    logic              bck_tc;
    logic              lrck_tc;

    // Terminal counts, last cycle of each half period
    assign bck_tc  = (bck_div == BCK_W'(BCK_HALF - 1));
    assign lrck_tc = (lrck_div == LRCK_W'(LRCK_HALF - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Bit clock divider
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge iCLK_18_4 or negedge iRST_N)
    begin
        if (!iRST_N)
        begin
            bck_div <= '0;
            aud_bck <= 1'b0;
        end
        else if (bck_tc)
        begin
            bck_div <= '0;
            aud_bck <= ~aud_bck;
        end
        else
        begin
            bck_div <= bck_div + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word clock divider
    ////////////////////////////////////////////////////////////////////////////
    // Half period is a whole number of bit clocks, so both dividers
    // reach terminal count together on a bit clock falling edge
    always_ff @(posedge iCLK_18_4 or negedge iRST_N)
    begin
        if (!iRST_N)
        begin
            lrck_div <= '0;
            aud_lrck <= 1'b0;
        end
        else if (lrck_tc)
        begin
            lrck_div <= '0;
            aud_lrck <= ~aud_lrck;
        end
        else
        begin
            lrck_div <= lrck_div + 1'b1;
        end
    end

    // Edge strobes, high in the cycle whose closing edge flips the level
    assign bck_rise    = bck_tc & ~aud_bck;
    assign bck_fall    = bck_tc & aud_bck;
    // Left slot start
    assign frame_start = lrck_tc & aud_lrck;

endmodule

//--- verilog/audio_codec_top.sv
`timescale 1ns/1ps

module audio_codec_top #(
    parameter int REF_CLK     = audio_pkg::DEF_REF_CLK,
    parameter int SAMPLE_RATE = audio_pkg::DEF_SAMPLE_RATE
) (
    input  logic               iCLK_18_4,
    input  logic               iRST_N,
    input  logic               tone_sel,
    input  audio_pkg::sample_t pulses,
    input  logic               aud_adcdat,
    output logic               aud_bck,
    output logic               aud_lrck,
    output logic               aud_adclrck,
    output logic               aud_data,
    output audio_pkg::sample_t linein
);

    // Strobes from the divider
    logic               bck_rise;
    logic               bck_fall;
    logic               frame_start;
    // Current sine point
    audio_pkg::sample_t tone_sample;

    ////////////////////////////////////////////////////////////////////////////
    // Clocking
    ////////////////////////////////////////////////////////////////////////////
    audio_clk_gen #(
        .REF_CLK     (REF_CLK),
        .SAMPLE_RATE (SAMPLE_RATE)
    ) u_audio_clk_gen (
        .iCLK_18_4   (iCLK_18_4),
        .iRST_N      (iRST_N),
        .aud_bck     (aud_bck),
        .aud_lrck    (aud_lrck),
        .bck_rise    (bck_rise),
        .bck_fall    (bck_fall),
        .frame_start (frame_start)
    );

    // ADC and DAC share one word clock
    assign aud_adclrck = aud_lrck;

    ////////////////////////////////////////////////////////////////////////////
    // Data paths
    ////////////////////////////////////////////////////////////////////////////
    tone_gen u_tone_gen (
        .iCLK_18_4   (iCLK_18_4),
        .iRST_N      (iRST_N),
        .frame_start (frame_start),
        .tone_sample (tone_sample)
    );

    audio_dac_serializer u_audio_dac_serializer (
        .iCLK_18_4   (iCLK_18_4),
        .iRST_N      (iRST_N),
        .bck_fall    (bck_fall),
        .frame_start (frame_start),
        .tone_sel    (tone_sel),
        .tone_sample (tone_sample),
        .pulses      (pulses),
        .aud_data    (aud_data)
    );

    audio_adc_deserializer u_audio_adc_deserializer (
        .iCLK_18_4   (iCLK_18_4),
        .iRST_N      (iRST_N),
        .bck_rise    (bck_rise),
        .frame_start (frame_start),
        .aud_adcdat  (aud_adcdat),
        .linein      (linein)
    );

endmodule

//--- verilog/audio_dac_serializer.sv
`timescale 1ns/1ps

module audio_dac_serializer (
    input  logic               iCLK_18_4,
    input  logic               iRST_N,
    input  logic               bck_fall,
    input  logic               frame_start,
    input  logic               tone_sel,
    input  audio_pkg::sample_t tone_sample,
    input  audio_pkg::sample_t pulses,
    output logic               aud_data
);

    // MSB position, first bit of every slot
    localparam audio_pkg::bit_idx_t MSB_IDX = audio_pkg::bit_idx_t'(audio_pkg::SAMPLE_BITS - 1);

    audio_pkg::sample_t  tx_word;
    audio_pkg::bit_idx_t tx_idx;

    ////////////////////////////////////////////////////////////////////////////
    // Sample latch and bit pointer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge iCLK_18_4 or negedge iRST_N)
    begin
        if (!iRST_N)
        begin
            // Line idles low until the first frame
            tx_word <= '0;
            tx_idx  <= MSB_IDX;
        end
        else if (frame_start)
        begin
            // Source chosen once per frame
            tx_word <= tone_sel ? tone_sample : pulses;
            tx_idx  <= MSB_IDX;
        end
        else if (bck_fall)
        begin
            // Wraps 0 to 15 at the right slot start
            tx_idx <= tx_idx - 1'b1;
        end
    end

    // Same word in both slots
    // Bit changes on bck falling edge, codec samples on the rising edge
    assign aud_data = tx_word[tx_idx];

endmodule

//--- verilog/audio_pkg.sv
package audio_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Frame format
    ////////////////////////////////////////////////////////////////////////////

    // Bits per channel slot, two slots per frame
    localparam int SAMPLE_BITS = 16;

    // Sine tone resolution, points per period
    localparam int TONE_POINTS = 48;

    // Board reference and codec frame rate, in Hz
    localparam int DEF_REF_CLK     = 18432000;
    localparam int DEF_SAMPLE_RATE = 48000;

    ////////////////////////////////////////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////////////////////////////////////////

    // One audio sample, two's complement on the wire
    typedef logic [SAMPLE_BITS-1:0] sample_t;

    // Sine table index, 0 to 47
    typedef logic [5:0] tone_addr_t;

    // Bit position inside a sample, MSB is 15
    typedef logic [3:0] bit_idx_t;

endpackage

//--- verilog/tone_gen.sv
`timescale 1ns/1ps

module tone_gen (
    input  logic               iCLK_18_4,
    input  logic               iRST_N,
    input  logic               frame_start,
    output audio_pkg::sample_t tone_sample
);

    audio_pkg::tone_addr_t tone_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Table address, one step per frame
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge iCLK_18_4 or negedge iRST_N)
    begin
        if (!iRST_N)
            tone_addr <= '0;
        else if (frame_start)
        begin
            // Wrap after the last point of the period
            if (tone_addr == audio_pkg::tone_addr_t'(audio_pkg::TONE_POINTS - 1))
                tone_addr <= '0;
            else
                tone_addr <= tone_addr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sine table, round(32767 * sin(2*pi*k/48))
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (tone_addr)
            // Positive half period
            6'd0:  tone_sample = 16'sd0;
            6'd1:  tone_sample = 16'sd4277;
            6'd2:  tone_sample = 16'sd8481;
            6'd3:  tone_sample = 16'sd12539;
            6'd4:  tone_sample = 16'sd16383;
            6'd5:  tone_sample = 16'sd19947;
            6'd6:  tone_sample = 16'sd23170;
            6'd7:  tone_sample = 16'sd25996;
            6'd8:  tone_sample = 16'sd28377;
            6'd9:  tone_sample = 16'sd30273;
            6'd10: tone_sample = 16'sd31650;
            6'd11: tone_sample = 16'sd32487;
            6'd12: tone_sample = 16'sd32767;
            6'd13: tone_sample = 16'sd32487;
            6'd14: tone_sample = 16'sd31650;
            6'd15: tone_sample = 16'sd30273;
            6'd16: tone_sample = 16'sd28377;
            6'd17: tone_sample = 16'sd25996;
            6'd18: tone_sample = 16'sd23170;
            6'd19: tone_sample = 16'sd19947;
            6'd20: tone_sample = 16'sd16383;
            6'd21: tone_sample = 16'sd12539;
            6'd22: tone_sample = 16'sd8481;
            6'd23: tone_sample = 16'sd4277;
            // Negative half period, mirror of the first
            6'd24: tone_sample = 16'sd0;
            6'd25: tone_sample = -16'sd4277;
            6'd26: tone_sample = -16'sd8481;
            6'd27: tone_sample = -16'sd12539;
            6'd28: tone_sample = -16'sd16383;
            6'd29: tone_sample = -16'sd19947;
            6'd30: tone_sample = -16'sd23170;
            6'd31: tone_sample = -16'sd25996;
            6'd32: tone_sample = -16'sd28377;
            6'd33: tone_sample = -16'sd30273;
            6'd34: tone_sample = -16'sd31650;
            6'd35: tone_sample = -16'sd32487;
            6'd36: tone_sample = -16'sd32767;
            6'd37: tone_sample = -16'sd32487;
            6'd38: tone_sample = -16'sd31650;
            6'd39: tone_sample = -16'sd30273;
            6'd40: tone_sample = -16'sd28377;
            6'd41: tone_sample = -16'sd25996;
            6'd42: tone_sample = -16'sd23170;
            6'd43: tone_sample = -16'sd19947;
            6'd44: tone_sample = -16'sd16383;
            6'd45: tone_sample = -16'sd12539;
            6'd46: tone_sample = -16'sd8481;
            6'd47: tone_sample = -16'sd4277;
            // Unreachable addresses
            default: tone_sample = '0;
        endcase
    end

endmodule
